//--- logic/gfx_pkg.sv
package gfx_pkg;

  // wide enough for any coordinate, width or height up to 1024
  localparam int coord_w = 10;

  typedef logic [coord_w-1:0] coord_t;

  // one pixel, 4 bits per channel
  typedef struct packed {
    logic [3:0] red;
    logic [3:0] grn;
    logic [3:0] blu;
  } rgb444_t;

  typedef enum logic {
    op_fill,
    op_clear
  } gfx_op_e;

  // what the host holds stable while cmd_req is high
  typedef struct packed {
    gfx_op_e op;
    coord_t  x0;
    coord_t  y0;
    coord_t  w;
    coord_t  h;
    rgb444_t color;
  } draw_cmd_t;

  // already checked against the visible area
  typedef struct packed {
    coord_t  x0;
    coord_t  y0;
    coord_t  w;
    coord_t  h;
    rgb444_t color;
  } rect_t;

  // syncs are active low
  typedef struct packed {
    coord_t x;
    coord_t y;
    logic   de;
    logic   hsync;
    logic   vsync;
  } scan_pos_t;

endpackage

//--- logic/gfx_cmd_intake.sv
module gfx_cmd_intake #(
  parameter int h_visible = 640,
  parameter int v_visible = 480
) (
  input  logic               pixel_clk,
  input  logic               rst_n,
  input  logic               cmd_req,
  input  gfx_pkg::draw_cmd_t cmd,
  output logic               cmd_ack,
  output logic               cmd_error,
  input  logic               rect_busy,
  output logic               rect_valid,
  output gfx_pkg::rect_t     rect
);

  typedef enum logic [1:0] {
    idle,
    acked,
    wait_low
  } state_e;

  state_e                    state;
  logic [gfx_pkg::coord_w:0] x_end;
  logic [gfx_pkg::coord_w:0] y_end;
  logic                      bad_size;
  logic                      out_of_bounds;
  logic                      reject;
  logic                      take;

  // extra top bit so the end coordinate cannot wrap
  assign x_end         = {1'b0, cmd.x0} + {1'b0, cmd.w};
  assign y_end         = {1'b0, cmd.y0} + {1'b0, cmd.h};
  assign bad_size      = (cmd.w == '0) || (cmd.h == '0);
  assign out_of_bounds = (x_end > h_visible) || (y_end > v_visible);

  // a clear ignores its coordinates, so it is never rejected
  assign reject = (cmd.op == gfx_pkg::op_fill) && (bad_size || out_of_bounds);

  // new command only when the rasterizer is free, otherwise the host waits
  assign take = (state == idle) && cmd_req && !rect_busy;

  always_ff @(posedge pixel_clk) begin
    if (!rst_n) begin
      state      <= idle;
      cmd_ack    <= 1'b0;
      cmd_error  <= 1'b0;
      rect_valid <= 1'b0;
    end else begin
      rect_valid <= 1'b0;
      case (state)
        idle: begin
          if (take) begin
            cmd_ack    <= 1'b1;
            cmd_error  <= reject;
            rect_valid <= !reject;
            state      <= acked;
          end
        end
        acked: begin
          // hold ack until the host lets go of req
          if (!cmd_req) begin
            cmd_ack   <= 1'b0;
            cmd_error <= 1'b0;
            state     <= wait_low;
          end
        end
        wait_low: begin
          // ack is low again, the host may already raise the next req
          state <= idle;
        end
        default: state <= idle;
      endcase
    end
  end

  always_ff @(posedge pixel_clk) begin
    if (take) begin
      if (cmd.op == gfx_pkg::op_clear) begin
        rect.x0 <= '0;
        rect.y0 <= '0;
        rect.w  <= gfx_pkg::coord_w'(h_visible);
        rect.h  <= gfx_pkg::coord_w'(v_visible);
      end else begin
        rect.x0 <= cmd.x0;
        rect.y0 <= cmd.y0;
        rect.w  <= cmd.w;
        rect.h  <= cmd.h;
      end
      rect.color <= cmd.color;
    end
  end

endmodule

//--- logic/gfx_rect_fill.sv
module gfx_rect_fill #(
  parameter int h_visible = 640,
  parameter int v_visible = 480,
  localparam int addr_w = $clog2(h_visible * v_visible)
) (
  input  logic              pixel_clk,
  input  logic              rst_n,
  input  logic              rect_valid,
  input  gfx_pkg::rect_t    rect,
  output logic              rect_busy,
  output logic              wr_en,
  output logic [addr_w-1:0] wr_addr,
  output gfx_pkg::rgb444_t  wr_color
);

  typedef enum logic {
    idle,
    fill
  } state_e;

  state_e            state;
  gfx_pkg::coord_t   w_q;
  gfx_pkg::coord_t   h_q;
  gfx_pkg::rgb444_t  color_q;
  gfx_pkg::coord_t   x_cnt;
  gfx_pkg::coord_t   y_cnt;
  logic [addr_w-1:0] row_base;
  logic              last_col;
  logic              last_row;

  assign last_col = (x_cnt == w_q - 1'b1);
  assign last_row = (y_cnt == h_q - 1'b1);

  always_ff @(posedge pixel_clk) begin
    if (!rst_n) begin
      state    <= idle;
      x_cnt    <= '0;
      y_cnt    <= '0;
      row_base <= '0;
    end else begin
      case (state)
        idle: begin
          if (rect_valid) begin
            state <= fill;
            x_cnt <= '0;
            y_cnt <= '0;
            // the only multiply, once per rectangle
            row_base <= addr_w'(rect.y0 * h_visible + rect.x0);
          end
        end
        fill: begin
          if (last_col) begin
            x_cnt    <= '0;
            row_base <= row_base + addr_w'(h_visible);
            if (last_row) begin
              state <= idle;
            end else begin
              y_cnt <= y_cnt + 1'b1;
            end
          end else begin
            x_cnt <= x_cnt + 1'b1;
          end
        end
        default: state <= idle;
      endcase
    end
  end

  always_ff @(posedge pixel_clk) begin
    if (state == idle && rect_valid) begin
      w_q     <= rect.w;
      h_q     <= rect.h;
      color_q <= rect.color;
    end
  end

  // one pixel written on every busy cycle
  assign rect_busy = (state == fill);
  assign wr_en     = (state == fill);
  assign wr_addr   = row_base + addr_w'(x_cnt);
  assign wr_color  = color_q;

endmodule

//--- logic/gfx_framebuffer.sv
module gfx_framebuffer #(
  parameter int h_visible = 640,
  parameter int v_visible = 480,
  localparam int depth = h_visible * v_visible,
  localparam int addr_w = $clog2(depth)
) (
  input  logic              pixel_clk,
  input  logic              wr_en,
  input  logic [addr_w-1:0] wr_addr,
  input  gfx_pkg::rgb444_t  wr_color,
  input  logic [addr_w-1:0] rd_addr,
  output gfx_pkg::rgb444_t  rd_color
);

  // row-major, one entry per visible pixel
  gfx_pkg::rgb444_t mem [depth];

  always_ff @(posedge pixel_clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_color;
    end
  end

  // read data comes out one cycle after the address
  always_ff @(posedge pixel_clk) begin
    rd_color <= mem[rd_addr];
  end

endmodule

//--- logic/vga_timing.sv
module vga_timing #(
  parameter int h_visible = 640,
  parameter int h_front   = 16,
  parameter int h_sync    = 96,
  parameter int h_back    = 48,
  parameter int v_visible = 480,
  parameter int v_front   = 10,
  parameter int v_sync    = 2,
  parameter int v_back    = 33
) (
  input  logic               pixel_clk,
  input  logic               rst_n,
  output gfx_pkg::scan_pos_t pos
);

  localparam int h_total      = h_visible + h_front + h_sync + h_back;
  localparam int v_total      = v_visible + v_front + v_sync + v_back;
  localparam int h_sync_start = h_visible + h_front;
  localparam int h_sync_end   = h_sync_start + h_sync;
  localparam int v_sync_start = v_visible + v_front;
  localparam int v_sync_end   = v_sync_start + v_sync;

  gfx_pkg::coord_t h_cnt;
  gfx_pkg::coord_t v_cnt;
  logic            h_last;
  logic            v_last;

  assign h_last = (h_cnt == gfx_pkg::coord_w'(h_total - 1));
  assign v_last = (v_cnt == gfx_pkg::coord_w'(v_total - 1));

  always_ff @(posedge pixel_clk) begin
    if (!rst_n) begin
      h_cnt <= '0;
      v_cnt <= '0;
    end else if (h_last) begin
      h_cnt <= '0;
      // line wrap advances the vertical counter
      if (v_last) begin
        v_cnt <= '0;
      end else begin
        v_cnt <= v_cnt + 1'b1;
      end
    end else begin
      h_cnt <= h_cnt + 1'b1;
    end
  end

  assign pos.x  = h_cnt;
  assign pos.y  = v_cnt;
  assign pos.de = (h_cnt < h_visible) && (v_cnt < v_visible);

  // both syncs active low inside their pulse window
  assign pos.hsync = !((h_cnt >= h_sync_start) && (h_cnt < h_sync_end));
  assign pos.vsync = !((v_cnt >= v_sync_start) && (v_cnt < v_sync_end));

endmodule

//--- logic/vga_scanout.sv
module vga_scanout #(
  parameter int h_visible = 640,
  parameter int v_visible = 480,
  localparam int addr_w = $clog2(h_visible * v_visible)
) (
  input  logic               pixel_clk,
  input  logic               rst_n,
  input  gfx_pkg::scan_pos_t pos,
  output logic [addr_w-1:0]  rd_addr,
  input  gfx_pkg::rgb444_t   rd_color,
  output logic [3:0]         vga_red,
  output logic [3:0]         vga_grn,
  output logic [3:0]         vga_blu,
  output logic               vga_hsync,
  output logic               vga_vsync,
  output logic               vga_de
);

  logic [addr_w-1:0] row_base;
  logic              de_d;
  logic              hsync_d;
  logic              vsync_d;

  // row_base follows pos.y without a multiply
  always_ff @(posedge pixel_clk) begin
    if (!rst_n) begin
      row_base <= '0;
    end else if (!pos.vsync) begin
      row_base <= '0;
    end else if (pos.de && pos.x == gfx_pkg::coord_w'(h_visible - 1)) begin
      row_base <= row_base + addr_w'(h_visible);
    end
  end

  assign rd_addr = row_base + addr_w'(pos.x);

  // stage 1 matches the memory read, stage 2 is the output register
  always_ff @(posedge pixel_clk) begin
    if (!rst_n) begin
      de_d      <= 1'b0;
      hsync_d   <= 1'b1;
      vsync_d   <= 1'b1;
      vga_de    <= 1'b0;
      vga_hsync <= 1'b1;
      vga_vsync <= 1'b1;
      vga_red   <= '0;
      vga_grn   <= '0;
      vga_blu   <= '0;
    end else begin
      de_d      <= pos.de;
      hsync_d   <= pos.hsync;
      vsync_d   <= pos.vsync;
      vga_de    <= de_d;
      vga_hsync <= hsync_d;
      vga_vsync <= vsync_d;
      // blank outside the visible area
      vga_red   <= de_d ? rd_color.red : 4'h0;
      vga_grn   <= de_d ? rd_color.grn : 4'h0;
      vga_blu   <= de_d ? rd_color.blu : 4'h0;
    end
  end

endmodule

//--- logic/gfx_shapes_top.sv
module gfx_shapes_top #(
  parameter int h_visible = 640,
  parameter int h_front   = 16,
  parameter int h_sync    = 96,
  parameter int h_back    = 48,
  parameter int v_visible = 480,
  parameter int v_front   = 10,
  parameter int v_sync    = 2,
  parameter int v_back    = 33
) (
  input  logic               pixel_clk,
  input  logic               rst_n,
  input  logic               cmd_req,
  input  gfx_pkg::draw_cmd_t cmd,
  output logic               cmd_ack,
  output logic               cmd_error,
  output logic               draw_busy,
  output logic [3:0]         vga_red,
  output logic [3:0]         vga_grn,
  output logic [3:0]         vga_blu,
  output logic               vga_hsync,
  output logic               vga_vsync,
  output logic               vga_de
);

  localparam int addr_w = $clog2(h_visible * v_visible);

  logic               rect_valid;
  gfx_pkg::rect_t     rect;
  logic               rect_busy;
  logic               wr_en;
  logic [addr_w-1:0]  wr_addr;
  gfx_pkg::rgb444_t   wr_color;
  gfx_pkg::scan_pos_t pos;
  logic [addr_w-1:0]  rd_addr;
  gfx_pkg::rgb444_t   rd_color;

  assign draw_busy = rect_busy;

  gfx_cmd_intake #(
    .h_visible(h_visible),
    .v_visible(v_visible)
  ) i_gfx_cmd_intake (
    .pixel_clk (pixel_clk),
    .rst_n     (rst_n),
    .cmd_req   (cmd_req),
    .cmd       (cmd),
    .cmd_ack   (cmd_ack),
    .cmd_error (cmd_error),
    .rect_busy (rect_busy),
    .rect_valid(rect_valid),
    .rect      (rect)
  );

  gfx_rect_fill #(
    .h_visible(h_visible),
    .v_visible(v_visible)
  ) i_gfx_rect_fill (
    .pixel_clk (pixel_clk),
    .rst_n     (rst_n),
    .rect_valid(rect_valid),
    .rect      (rect),
    .rect_busy (rect_busy),
    .wr_en     (wr_en),
    .wr_addr   (wr_addr),
    .wr_color  (wr_color)
  );

  gfx_framebuffer #(
    .h_visible(h_visible),
    .v_visible(v_visible)
  ) i_gfx_framebuffer (
    .pixel_clk(pixel_clk),
    .wr_en    (wr_en),
    .wr_addr  (wr_addr),
    .wr_color (wr_color),
    .rd_addr  (rd_addr),
    .rd_color (rd_color)
  );

  vga_timing #(
    .h_visible(h_visible),
    .h_front  (h_front),
    .h_sync   (h_sync),
    .h_back   (h_back),
    .v_visible(v_visible),
    .v_front  (v_front),
    .v_sync   (v_sync),
    .v_back   (v_back)
  ) i_vga_timing (
    .pixel_clk(pixel_clk),
    .rst_n    (rst_n),
    .pos      (pos)
  );

  vga_scanout #(
    .h_visible(h_visible),
    .v_visible(v_visible)
  ) i_vga_scanout (
    .pixel_clk(pixel_clk),
    .rst_n    (rst_n),
    .pos      (pos),
    .rd_addr  (rd_addr),
    .rd_color (rd_color),
    .vga_red  (vga_red),
    .vga_grn  (vga_grn),
    .vga_blu  (vga_blu),
    .vga_hsync(vga_hsync),
    .vga_vsync(vga_vsync),
    .vga_de   (vga_de)
  );

endmodule

//--- verification/gfx_shapes_assert.sv
module gfx_shapes_assert (
  input logic pixel_clk,
  input logic rst_n,
  input logic cmd_req,
  input logic cmd_ack,
  input logic rect_valid,
  input logic rect_busy,
  input logic vga_de,
  input logic vga_hsync,
  input logic vga_vsync
);
  timeunit 1ns;
  timeprecision 1ps;

  // ack only answers a pending req
  a_ack_needs_req: assert property (@(posedge pixel_clk) disable iff (!rst_n)
    $rose(cmd_ack) |-> $past(cmd_req))
    else $error("cmd_ack rose without cmd_req");

  a_ack_after_req: assert property (@(posedge pixel_clk) disable iff (!rst_n)
    $fell(cmd_ack) |-> !$past(cmd_req))
    else $error("cmd_ack fell while cmd_req was high");

  // rasterizer takes one rectangle at a time
  a_valid_not_busy: assert property (@(posedge pixel_clk) disable iff (!rst_n)
    rect_valid |-> !rect_busy)
    else $error("rect_valid pulsed while rect_busy was high");

  a_de_blank: assert property (@(posedge pixel_clk) disable iff (!rst_n)
    vga_de |-> (vga_hsync && vga_vsync))
    else $error("vga_de high during a sync pulse");

endmodule

bind gfx_cmd_intake gfx_shapes_assert i_intake_assert (
  .pixel_clk (pixel_clk),
  .rst_n     (rst_n),
  .cmd_req   (cmd_req),
  .cmd_ack   (cmd_ack),
  .rect_valid(rect_valid),
  .rect_busy (rect_busy),
  .vga_de    (1'b0),
  .vga_hsync (1'b1),
  .vga_vsync (1'b1)
);

bind gfx_shapes_top gfx_shapes_assert i_top_assert (
  .pixel_clk (pixel_clk),
  .rst_n     (rst_n),
  .cmd_req   (1'b0),
  .cmd_ack   (1'b0),
  .rect_valid(1'b0),
  .rect_busy (1'b0),
  .vga_de    (vga_de),
  .vga_hsync (vga_hsync),
  .vga_vsync (vga_vsync)
);

//--- verification/gfx_shapes_tb.sv
module gfx_shapes_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int h_visible = 16;
  localparam int h_front   = 2;
  localparam int h_sync    = 4;
  localparam int h_back    = 2;
  localparam int v_visible = 12;
  localparam int v_front   = 1;
  localparam int v_sync    = 2;
  localparam int v_back    = 1;

  localparam int h_total         = h_visible + h_front + h_sync + h_back;
  localparam int v_total         = v_visible + v_front + v_sync + v_back;
  localparam int frame_cycles    = h_total * v_total;
  localparam int n_pix           = h_visible * v_visible;
  localparam int n_entries       = 12;
  localparam int watchdog_cycles = n_entries * 3 * frame_cycles + 2000;

  // one command, its expected cmd_error and whether a frame check follows it
  typedef struct packed {
    gfx_pkg::gfx_op_e op;
    logic [9:0]       x0;
    logic [9:0]       y0;
    logic [9:0]       w;
    logic [9:0]       h;
    logic [11:0]      color;
    logic             rand_color;
    logic             exp_err;
    logic             check_after;
  } entry_t;

  logic               pixel_clk;
  logic               rst_n;
  logic               cmd_req;
  gfx_pkg::draw_cmd_t cmd;
  logic               cmd_ack;
  logic               cmd_error;
  logic               draw_busy;
  logic [3:0]         vga_red;
  logic [3:0]         vga_grn;
  logic [3:0]         vga_blu;
  logic               vga_hsync;
  logic               vga_vsync;
  logic               vga_de;

  entry_t      cmds [n_entries];
  logic [11:0] model [n_pix];
  int          seed;
  int          mismatch_cnt;
  int          other_cnt;

  gfx_shapes_top #(
    .h_visible(h_visible),
    .h_front  (h_front),
    .h_sync   (h_sync),
    .h_back   (h_back),
    .v_visible(v_visible),
    .v_front  (v_front),
    .v_sync   (v_sync),
    .v_back   (v_back)
  ) i_gfx_shapes_top (
    .pixel_clk(pixel_clk),
    .rst_n    (rst_n),
    .cmd_req  (cmd_req),
    .cmd      (cmd),
    .cmd_ack  (cmd_ack),
    .cmd_error(cmd_error),
    .draw_busy(draw_busy),
    .vga_red  (vga_red),
    .vga_grn  (vga_grn),
    .vga_blu  (vga_blu),
    .vga_hsync(vga_hsync),
    .vga_vsync(vga_vsync),
    .vga_de   (vga_de)
  );

  initial begin
    pixel_clk = 1'b0;
  end

  always #20 pixel_clk = ~pixel_clk;

  // reference picture, later commands overwrite earlier ones
  task automatic paint_model(input entry_t e, input logic [11:0] color);
    int x;
    int y;
    for (y = 0; y < v_visible; y++) begin
      for (x = 0; x < h_visible; x++) begin
        if (e.op == gfx_pkg::op_clear ||
            (x >= e.x0 && x < e.x0 + e.w && y >= e.y0 && y < e.y0 + e.h)) begin
          model[y * h_visible + x] = color;
        end
      end
    end
  endtask

  // full four-phase handshake for one command
  task automatic send_cmd(input int idx, input entry_t e, input logic [11:0] color);
    gfx_pkg::draw_cmd_t c;
    c.op    = e.op;
    c.x0    = e.x0;
    c.y0    = e.y0;
    c.w     = e.w;
    c.h     = e.h;
    c.color = color;
    @(posedge pixel_clk);
    cmd     <= c;
    cmd_req <= 1'b1;
    @(negedge pixel_clk);
    while (!cmd_ack) @(negedge pixel_clk);
    if (cmd_error !== e.exp_err) begin
      mismatch_cnt++;
      $display("Mismatch cmd_error entry %0d: got %h expected %h", idx, cmd_error, e.exp_err);
    end
    @(posedge pixel_clk);
    cmd_req <= 1'b0;
    @(negedge pixel_clk);
    if (!cmd_ack) begin
      other_cnt++;
      $display("entry %0d: ack dropped while req was still high", idx);
    end
    while (cmd_ack) @(negedge pixel_clk);
  endtask

  // one frame, starting at the first vsync low cycle
  task automatic capture_frame();
    int          pix;
    int          de_run;
    int          de_lines;
    int          hs_run;
    int          hs_pulses;
    int          vs_low;
    logic [11:0] got;
    logic        prev_vs;
    pix       = 0;
    de_run    = 0;
    de_lines  = 0;
    hs_run    = 0;
    hs_pulses = 0;
    vs_low    = 0;
    @(negedge pixel_clk);
    while (draw_busy) @(negedge pixel_clk);
    prev_vs = 1'b0;
    while (!(prev_vs && !vga_vsync)) begin
      prev_vs = vga_vsync;
      @(negedge pixel_clk);
    end
    repeat (frame_cycles) begin
      if (vga_de) begin
        got = {vga_red, vga_grn, vga_blu};
        if (pix < n_pix && got !== model[pix]) begin
          mismatch_cnt++;
          $display("Mismatch vga_red/vga_grn/vga_blu at x %0d y %0d: got %h expected %h",
                   pix % h_visible, pix / h_visible, got, model[pix]);
        end
        pix++;
        de_run++;
      end else if (de_run != 0) begin
        if (de_run != h_visible) begin
          mismatch_cnt++;
          $display("Mismatch vga_de run: got %h expected %h", de_run, h_visible);
        end
        de_lines++;
        de_run = 0;
      end
      if (!vga_hsync) begin
        hs_run++;
      end else if (hs_run != 0) begin
        if (hs_run != h_sync) begin
          mismatch_cnt++;
          $display("Mismatch vga_hsync low length: got %h expected %h", hs_run, h_sync);
        end
        hs_pulses++;
        hs_run = 0;
      end
      if (!vga_vsync) vs_low++;
      @(negedge pixel_clk);
    end
    if (de_lines != v_visible || pix != n_pix) begin
      mismatch_cnt++;
      $display("Mismatch vga_de lines: got %h expected %h", de_lines, v_visible);
    end
    if (hs_pulses != v_total) begin
      mismatch_cnt++;
      $display("Mismatch vga_hsync pulses: got %h expected %h", hs_pulses, v_total);
    end
    if (vs_low != v_sync * h_total) begin
      mismatch_cnt++;
      $display("Mismatch vga_vsync low cycles: got %h expected %h", vs_low, v_sync * h_total);
    end
  endtask

  initial begin
    logic [11:0] color;
    seed         = 65287;
    mismatch_cnt = 0;
    other_cnt    = 0;
    rst_n        = 1'b0;
    cmd_req      = 1'b0;
    cmd          = '0;
    // clear, then overlapping fills
    cmds[0]  = '{gfx_pkg::op_clear, 10'd0, 10'd0, 10'd0, 10'd0, 12'h123, 1'b0, 1'b0, 1'b1};
    cmds[1]  = '{gfx_pkg::op_fill, 10'd2, 10'd1, 10'd6, 10'd5, 12'h000, 1'b1, 1'b0, 1'b0};
    cmds[2]  = '{gfx_pkg::op_fill, 10'd5, 10'd3, 10'd8, 10'd6, 12'h000, 1'b1, 1'b0, 1'b0};
    cmds[3]  = '{gfx_pkg::op_fill, 10'd0, 10'd10, 10'd16, 10'd2, 12'hf0f, 1'b0, 1'b0, 1'b1};
    // rejected commands leave the picture alone
    cmds[4]  = '{gfx_pkg::op_fill, 10'd10, 10'd0, 10'd8, 10'd2, 12'hfff, 1'b0, 1'b1, 1'b0};
    cmds[5]  = '{gfx_pkg::op_fill, 10'd0, 10'd0, 10'd0, 10'd3, 12'hfff, 1'b0, 1'b1, 1'b0};
    cmds[6]  = '{gfx_pkg::op_fill, 10'd3, 10'd11, 10'd2, 10'd2, 12'hfff, 1'b0, 1'b1, 1'b1};
    // large fill keeps the rasterizer busy while the next one waits
    cmds[7]  = '{gfx_pkg::op_fill, 10'd0, 10'd0, 10'd16, 10'd12, 12'h0a5, 1'b0, 1'b0, 1'b0};
    cmds[8]  = '{gfx_pkg::op_fill, 10'd1, 10'd1, 10'd3, 10'd3, 12'h000, 1'b1, 1'b0, 1'b0};
    cmds[9]  = '{gfx_pkg::op_fill, 10'd12, 10'd8, 10'd4, 10'd4, 12'h777, 1'b0, 1'b0, 1'b1};
    // clear ignores its coordinates
    cmds[10] = '{gfx_pkg::op_clear, 10'd900, 10'd3, 10'd0, 10'd0, 12'h9c3, 1'b0, 1'b0, 1'b0};
    cmds[11] = '{gfx_pkg::op_fill, 10'd4, 10'd4, 10'd8, 10'd4, 12'h000, 1'b1, 1'b0, 1'b1};
    repeat (4) @(posedge pixel_clk);
    rst_n <= 1'b1;
    for (int i = 0; i < n_entries; i++) begin
      color = cmds[i].rand_color ? 12'($random(seed)) : cmds[i].color;
      send_cmd(i, cmds[i], color);
      if (!cmds[i].exp_err) paint_model(cmds[i], color);
      if (cmds[i].check_after) capture_frame();
    end
    $display("errors: %0d mismatches, %0d other failures", mismatch_cnt, other_cnt);
    if (mismatch_cnt == 0 && other_cnt == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  initial begin
    repeat (watchdog_cycles) @(posedge pixel_clk);
    $display("timeout: run did not finish within %0d cycles", watchdog_cycles);
    $display("Verification failed");
    $finish;
  end

endmodule

//--- sim.f
logic/gfx_pkg.sv
logic/gfx_cmd_intake.sv
logic/gfx_rect_fill.sv
logic/gfx_framebuffer.sv
logic/vga_timing.sv
logic/vga_scanout.sv
logic/gfx_shapes_top.sv
verification/gfx_shapes_assert.sv
verification/gfx_shapes_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
build_log=build.log
sim_log=sim.log
fail_msg="Verification failed"
pass_msg="Verification passed"

verilator --binary --timing --assert -Wno-fatal \
  --top-module gfx_shapes_tb -f sim.f \
  -Mdir "$build_dir" -o gfx_shapes_sim > "$build_log" 2>&1
build_status=$?
if [ "$build_status" -ne 0 ]; then
  echo "build failed with status $build_status, see $build_log"
  exit 1
fi

"./$build_dir/gfx_shapes_sim" > "$sim_log" 2>&1
sim_status=$?
cat "$sim_log"

if grep -q "$fail_msg" "$sim_log"; then
  echo "simulation reported failure"
  exit 1
fi
if [ "$sim_status" -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi
if ! grep -q "$pass_msg" "$sim_log"; then
  echo "simulation ended without a result"
  exit 1
fi
exit 0
